/* dv/axi_lite_mem.sv */
`timescale 1ns/1ps

module axi_lite_mem (
    input  logic        clk,
    input  logic        reset,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp
);

    // 4 KiB, indexed by address bits 11:2
    logic [31:0] mem [0:1023];
    integer      seed;
    logic [1:0]  aw_wait;
    logic [1:0]  w_wait;
    logic [1:0]  ar_wait;
    logic        aw_got;
    logic        w_got;
    logic [31:0] wr_addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_strb;

    function automatic logic in_err_window(input logic [31:0] a);
        return (a >= 32'h8000_0f00) && (a <= 32'h8000_0fff);
    endfunction

    // ready delay of 0 to 3 cycles
    function logic [1:0] next_delay();
        logic [31:0] r;
        r = $random(seed);
        return r[1:0];
    endfunction

    initial begin
        seed = 32'h58da_13ac;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h3c00_0000 ^ (i * 32'h0004_0081);
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            aw_wait <= 2'd0;
            w_wait  <= 2'd0;
            ar_wait <= 2'd0;
            bresp   <= axi_pkg::OKAY;
            rresp   <= axi_pkg::OKAY;
            rdata   <= 32'h0;
        end else begin
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
                aw_wait <= next_delay();
            end else if (awvalid && !aw_got) begin
                if (aw_wait == 2'd0) begin
                    awready <= 1'b1;
                end else begin
                    aw_wait <= aw_wait - 2'd1;
                end
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
                w_wait  <= next_delay();
            end else if (wvalid && !w_got) begin
                if (w_wait == 2'd0) begin
                    wready <= 1'b1;
                end else begin
                    w_wait <= w_wait - 2'd1;
                end
            end
            // write response once both halves are in
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                aw_got <= 1'b0;
                w_got  <= 1'b0;
            end else if (aw_got && w_got && !bvalid) begin
                if (!in_err_window(wr_addr)) begin
                    for (int i = 0; i < 4; i++) begin
                        if (wr_strb[i]) begin
                            mem[wr_addr[11:2]][i*8 +: 8] <= wr_data[i*8 +: 8];
                        end
                    end
                end
                bresp  <= in_err_window(wr_addr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
                bvalid <= 1'b1;
            end
            if (arvalid && arready) begin
                arready <= 1'b0;
                ar_wait <= next_delay();
                rvalid  <= 1'b1;
                rdata   <= in_err_window(araddr) ? 32'h0 : mem[araddr[11:2]];
                rresp   <= in_err_window(araddr) ? axi_pkg::SLVERR : axi_pkg::OKAY;
            end else if (arvalid && !rvalid) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

    localparam logic [31:0] CLINT_BASE = 32'ha000_0040;

    logic               clk;
    logic               reset;
    logic               req;
    logic               we;
    logic               is_signed;
    lsu_pkg::mem_size_e size;
    logic [31:0]        addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;
    logic               done;
    logic               err;
    logic               timer_irq;
    logic               m_axi_awvalid;
    logic               m_axi_awready;
    logic [31:0]        m_axi_awaddr;
    logic [2:0]         m_axi_awsize;
    logic               m_axi_wvalid;
    logic               m_axi_wready;
    logic [31:0]        m_axi_wdata;
    logic [3:0]         m_axi_wstrb;
    logic               m_axi_bvalid;
    logic               m_axi_bready;
    logic [1:0]         m_axi_bresp;
    logic               m_axi_arvalid;
    logic               m_axi_arready;
    logic [31:0]        m_axi_araddr;
    logic [2:0]         m_axi_arsize;
    logic               m_axi_rvalid;
    logic               m_axi_rready;
    logic [31:0]        m_axi_rdata;
    logic [1:0]         m_axi_rresp;
    integer             seed;
    int                 mismatches;
    int                 failures;

    lsu_top #(
        .CLINT_BASE  (CLINT_BASE),
        .MTIME_RESET (64'h0)
    ) u_lsu_top (.*);

    axi_lite_mem u_mem (
        .clk     (clk),
        .reset   (reset),
        .awvalid (m_axi_awvalid),
        .awready (m_axi_awready),
        .awaddr  (m_axi_awaddr),
        .wvalid  (m_axi_wvalid),
        .wready  (m_axi_wready),
        .wdata   (m_axi_wdata),
        .wstrb   (m_axi_wstrb),
        .bvalid  (m_axi_bvalid),
        .bready  (m_axi_bready),
        .bresp   (m_axi_bresp),
        .arvalid (m_axi_arvalid),
        .arready (m_axi_arready),
        .araddr  (m_axi_araddr),
        .rvalid  (m_axi_rvalid),
        .rready  (m_axi_rready),
        .rdata   (m_axi_rdata),
        .rresp   (m_axi_rresp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_size(input string name, input lsu_pkg::mem_size_e got,
                              input lsu_pkg::mem_size_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    function automatic lsu_pkg::mem_size_e size_from_axsize(input logic [2:0] axsize);
        case (axsize)
            axi_pkg::AXSIZE_B: return lsu_pkg::SIZE_B;
            axi_pkg::AXSIZE_H: return lsu_pkg::SIZE_H;
            axi_pkg::AXSIZE_W: return lsu_pkg::SIZE_W;
            default:           return lsu_pkg::mem_size_e'(2'd0);
        endcase
    endfunction

    // expected memory word after a store, from the lane and shift rule
    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] d,
                                                input lsu_pkg::mem_size_e sz,
                                                input logic [1:0] off);
        logic [3:0]  lanes;
        logic [31:0] shifted;
        logic [31:0] res;
        shifted = d << (8 * off);
        case (sz)
            lsu_pkg::SIZE_B: lanes = 4'b0001 << off;
            lsu_pkg::SIZE_H: lanes = off[1] ? 4'b1100 : 4'b0011;
            default:         lanes = 4'b1111;
        endcase
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (lanes[i]) begin
                res[i*8 +: 8] = shifted[i*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] extract_load(input logic [31:0] word,
                                                 input lsu_pkg::mem_size_e sz,
                                                 input logic [1:0] off, input logic sgn);
        logic [31:0] s;
        s = word >> (8 * off);
        case (sz)
            lsu_pkg::SIZE_B: return sgn ? {{24{s[7]}}, s[7:0]} : {24'h0, s[7:0]};
            lsu_pkg::SIZE_H: return sgn ? {{16{s[15]}}, s[15:0]} : {16'h0, s[15:0]};
            default:         return s;
        endcase
    endfunction

    // one request, waits for done; lat counts cycles after the req cycle
    task automatic run_access(input logic wr, input logic sgn, input lsu_pkg::mem_size_e sz,
                              input logic [31:0] a, input logic [31:0] d,
                              output logic [31:0] rd, output logic e, output int lat);
        logic       got;
        logic       on_clint;
        logic       ax_seen;
        logic [2:0] ax_size;
        got      = 1'b0;
        ax_seen  = 1'b0;
        ax_size  = 3'd0;
        lat      = 0;
        rd       = 32'h0;
        e        = 1'b0;
        on_clint = (a[31:4] == CLINT_BASE[31:4]);
        @(posedge clk);
        req       <= 1'b1;
        we        <= wr;
        is_signed <= sgn;
        size      <= sz;
        addr      <= a;
        wdata     <= d;
        while (!got && lat < 200) begin
            @(negedge clk);
            if (on_clint && (m_axi_awvalid || m_axi_arvalid)) begin
                $display("AXI valid raised during CLINT access to %h", a);
                failures++;
            end
            if (m_axi_awvalid || m_axi_arvalid) begin
                ax_seen = 1'b1;
                ax_size = m_axi_awvalid ? m_axi_awsize : m_axi_arsize;
            end
            if (done) begin
                got = 1'b1;
                rd  = rdata;
                e   = err;
            end else begin
                @(posedge clk);
                req <= 1'b0;
                lat++;
            end
        end
        if (!got) begin
            $display("no done within timeout, access to %h", a);
            failures++;
        end else if (!on_clint) begin
            if (!ax_seen) begin
                $display("no AXI address phase seen for access to %h", a);
                failures++;
            end else begin
                check_size("m_axi_axsize", size_from_axsize(ax_size), sz);
            end
        end
    endtask

    task automatic write_mem(input lsu_pkg::mem_size_e sz, input logic [31:0] a,
                             input logic [31:0] d, input logic exp_err);
        logic [31:0] rd;
        logic        e;
        int          lat;
        run_access(1'b1, 1'b0, sz, a, d, rd, e, lat);
        check_flag($sformatf("err @%h", a), e, exp_err);
    endtask

    task automatic read_mem(input logic sgn, input lsu_pkg::mem_size_e sz,
                            input logic [31:0] a, input logic [31:0] exp,
                            input logic exp_err);
        logic [31:0] rd;
        logic        e;
        int          lat;
        run_access(1'b0, sgn, sz, a, 32'h0, rd, e, lat);
        check_flag($sformatf("err @%h", a), e, exp_err);
        if (!exp_err) begin
            check_word($sformatf("rdata @%h", a), rd, exp);
        end
    endtask

    // CLINT word access, always two cycles from req to done
    task automatic clint_access(input logic wr, input logic [3:0] off, input logic [31:0] d,
                                output logic [31:0] rd);
        logic e;
        int   lat;
        run_access(wr, 1'b0, lsu_pkg::SIZE_W, CLINT_BASE + off, d, rd, e, lat);
        check_word("clint done latency", 32'(lat), 32'd2);
        check_flag("clint err", e, 1'b0);
    endtask

    task automatic test_word_round_trip();
        logic [31:0] data [6];
        for (int i = 0; i < 6; i++) begin
            data[i] = $random(seed);
            write_mem(lsu_pkg::SIZE_W, 32'h8000_0000 + i * 32'h84, data[i], 1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            read_mem(1'b0, lsu_pkg::SIZE_W, 32'h8000_0000 + i * 32'h84, data[i], 1'b0);
        end
    endtask

    task automatic test_subword_stores();
        logic [31:0] exp;
        logic [31:0] d;
        exp = 32'h1122_3344;
        write_mem(lsu_pkg::SIZE_W, 32'h8000_0400, exp, 1'b0);
        for (int off = 0; off < 4; off++) begin
            d = $random(seed);
            write_mem(lsu_pkg::SIZE_B, 32'h8000_0400 + off, d, 1'b0);
            exp = merge_store(exp, d, lsu_pkg::SIZE_B, 2'(off));
            read_mem(1'b0, lsu_pkg::SIZE_W, 32'h8000_0400, exp, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            d = $random(seed);
            write_mem(lsu_pkg::SIZE_H, 32'h8000_0400 + off, d, 1'b0);
            exp = merge_store(exp, d, lsu_pkg::SIZE_H, 2'(off));
            read_mem(1'b0, lsu_pkg::SIZE_W, 32'h8000_0400, exp, 1'b0);
        end
    endtask

    task automatic test_subword_loads();
        logic [31:0] word;
        // every byte and half has its top bit set
        word = 32'hf2a4_8c91;
        write_mem(lsu_pkg::SIZE_W, 32'h8000_0500, word, 1'b0);
        for (int s = 0; s < 2; s++) begin
            for (int off = 0; off < 4; off++) begin
                read_mem(s == 1, lsu_pkg::SIZE_B, 32'h8000_0500 + off,
                         extract_load(word, lsu_pkg::SIZE_B, 2'(off), s == 1), 1'b0);
            end
            for (int off = 0; off < 4; off += 2) begin
                read_mem(s == 1, lsu_pkg::SIZE_H, 32'h8000_0500 + off,
                         extract_load(word, lsu_pkg::SIZE_H, 2'(off), s == 1), 1'b0);
            end
        end
    endtask

    task automatic test_bus_errors();
        write_mem(lsu_pkg::SIZE_W, 32'h8000_0f40, 32'hdead_beef, 1'b1);
        read_mem(1'b0, lsu_pkg::SIZE_W, 32'h8000_0f80, 32'h0, 1'b1);
        write_mem(lsu_pkg::SIZE_W, 32'h8000_0600, 32'h0bad_f00d, 1'b0);
        read_mem(1'b0, lsu_pkg::SIZE_W, 32'h8000_0600, 32'h0bad_f00d, 1'b0);
    endtask

    task automatic test_clint_timer();
        lsu_pkg::timer_word_u wr_val;
        lsu_pkg::timer_word_u now;
        lsu_pkg::timer_word_u cmp;
        logic [31:0]          rd;
        logic [31:0]          diff;
        int                   n;
        wr_val.count = 64'h0000_0000_0000_1000;
        clint_access(1'b1, lsu_pkg::CLINT_MTIME_LO, wr_val.half.lo, rd);
        clint_access(1'b1, lsu_pkg::CLINT_MTIME_HI, wr_val.half.hi, rd);
        clint_access(1'b0, lsu_pkg::CLINT_MTIME_LO, 32'h0, rd);
        diff = rd - wr_val.half.lo;
        if (diff < 32'd1 || diff > 32'd8) begin
            $display("mtime lo read %h is not 1 to 8 ticks past written %h", rd, wr_val.half.lo);
            failures++;
        end
        clint_access(1'b0, lsu_pkg::CLINT_MTIME_LO, 32'h0, rd);
        now.half.lo = rd;
        clint_access(1'b0, lsu_pkg::CLINT_MTIME_HI, 32'h0, rd);
        now.half.hi = rd;
        cmp.count = now.count + 64'd20;
        clint_access(1'b1, lsu_pkg::CLINT_CMP_LO, cmp.half.lo, rd);
        clint_access(1'b1, lsu_pkg::CLINT_CMP_HI, cmp.half.hi, rd);
        check_flag("timer_irq", timer_irq, 1'b0);
        n = 0;
        while (!timer_irq && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (!timer_irq) begin
            $display("timer_irq not raised within 40 cycles of the mtimecmp write");
            failures++;
        end
    endtask

    initial begin
        seed       = 32'h58da_13ac;
        mismatches = 0;
        failures   = 0;
        reset      = 1'b1;
        req        = 1'b0;
        we         = 1'b0;
        is_signed  = 1'b0;
        size       = lsu_pkg::SIZE_W;
        addr       = 32'h0;
        wdata      = 32'h0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_word_round_trip();
        test_subword_stores();
        test_subword_loads();
        test_bus_errors();
        test_clint_timer();
        $display("checks: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
src/lsu_pkg.sv
src/axi_pkg.sv
src/lsu_store_align.sv
src/lsu_load_extract.sv
src/lsu_ctrl_fsm.sv
src/clint_timer.sv
src/lsu_top.sv
dv/axi_lite_mem.sv
dv/lsu_tb.sv

/* src/axi_pkg.sv */
package axi_pkg;

    // xRESP encoding
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    // AxSIZE values for the three access widths
    localparam logic [2:0] AXSIZE_B = 3'd0;
    localparam logic [2:0] AXSIZE_H = 3'd1;
    localparam logic [2:0] AXSIZE_W = 3'd2;

endpackage

/* src/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer #(
    parameter logic [63:0] MTIME_RESET = 64'h0
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        sel,
    input  logic        we,
    input  logic [3:0]  off,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic [31:0] rdata,
    output logic        timer_irq
);

    lsu_pkg::timer_word_u mtime;
    lsu_pkg::timer_word_u mtimecmp;
    logic                 wr_en;
    logic                 mtime_wr;

    // byte-wise merge of a write into one 32-bit half
    function automatic logic [31:0] merge(input logic [31:0] old_val,
                                          input logic [31:0] new_val,
                                          input logic [3:0]  strb);
        logic [31:0] res;
        for (int i = 0; i < 4; i++) begin
            res[i*8 +: 8] = strb[i] ? new_val[i*8 +: 8] : old_val[i*8 +: 8];
        end
        return res;
    endfunction

    assign wr_en    = sel && we;
    assign mtime_wr = wr_en && (off == lsu_pkg::CLINT_MTIME_LO ||
                                off == lsu_pkg::CLINT_MTIME_HI);

    always_ff @(posedge clk) begin
        if (reset) begin
            mtime.count    <= MTIME_RESET;
            mtimecmp.count <= '1;
            timer_irq      <= 1'b0;
        end else begin
            if (mtime_wr) begin
                // a written cycle does not count
                if (off == lsu_pkg::CLINT_MTIME_LO) begin
                    mtime.half.lo <= merge(mtime.half.lo, wdata, wstrb);
                end else begin
                    mtime.half.hi <= merge(mtime.half.hi, wdata, wstrb);
                end
            end else begin
                mtime.count <= mtime.count + 64'd1;
            end
            if (wr_en && off == lsu_pkg::CLINT_CMP_LO) begin
                mtimecmp.half.lo <= merge(mtimecmp.half.lo, wdata, wstrb);
            end
            if (wr_en && off == lsu_pkg::CLINT_CMP_HI) begin
                mtimecmp.half.hi <= merge(mtimecmp.half.hi, wdata, wstrb);
            end
            timer_irq <= (mtime.count >= mtimecmp.count);
        end
    end

    // registered read, value seen in the select cycle
    always_ff @(posedge clk) begin
        if (sel) begin
            case (off)
                lsu_pkg::CLINT_MTIME_LO: rdata <= mtime.half.lo;
                lsu_pkg::CLINT_MTIME_HI: rdata <= mtime.half.hi;
                lsu_pkg::CLINT_CMP_LO:   rdata <= mtimecmp.half.lo;
                lsu_pkg::CLINT_CMP_HI:   rdata <= mtimecmp.half.hi;
                default:                 rdata <= 32'h0;
            endcase
        end
    end

endmodule

/* src/lsu_ctrl_fsm.sv */
`timescale 1ns/1ps

module lsu_ctrl_fsm #(
    parameter logic [31:0] CLINT_BASE = 32'ha000_0040
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               we,
    input  logic               is_signed,
    input  lsu_pkg::mem_size_e size,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata_aligned,
    input  logic [3:0]         wstrb,
    output lsu_pkg::mem_size_e op_size,
    output logic [1:0]         op_off,
    output logic               op_signed,
    output logic [31:0]        raw_rdata,
    output logic               done,
    output logic               err,
    output logic               m_axi_awvalid,
    input  logic               m_axi_awready,
    output logic [31:0]        m_axi_awaddr,
    output logic [2:0]         m_axi_awsize,
    output logic               m_axi_wvalid,
    input  logic               m_axi_wready,
    output logic [31:0]        m_axi_wdata,
    output logic [3:0]         m_axi_wstrb,
    input  logic               m_axi_bvalid,
    output logic               m_axi_bready,
    input  logic [1:0]         m_axi_bresp,
    output logic               m_axi_arvalid,
    input  logic               m_axi_arready,
    output logic [31:0]        m_axi_araddr,
    output logic [2:0]         m_axi_arsize,
    input  logic               m_axi_rvalid,
    output logic               m_axi_rready,
    input  logic [31:0]        m_axi_rdata,
    input  logic [1:0]         m_axi_rresp,
    input  logic [31:0]        clint_rdata,
    output logic               clint_sel,
    output logic               clint_we,
    output logic [3:0]         clint_off,
    output logic [31:0]        clint_wdata,
    output logic [3:0]         clint_wstrb
);

    typedef enum logic [2:0] {
        IDLE,
        CLINT,
        AXI_WR,
        AXI_WR_RESP,
        AXI_RD,
        AXI_RD_RESP
    } state_e;

    state_e      state;
    logic        op_we;
    logic        op_clint;
    logic [31:0] op_addr;
    logic [31:0] op_wdata;
    logic [3:0]  op_wstrb;
    logic [31:0] axi_rdata;
    logic [2:0]  op_axsize;
    logic        aw_pend;
    logic        w_pend;
    logic        ar_pend;
    logic        in_window;
    logic        aw_done;
    logic        w_done;

    function automatic logic resp_is_err(input logic [1:0] resp);
        return (resp == axi_pkg::SLVERR) || (resp == axi_pkg::DECERR);
    endfunction

    // 16 byte window, base is aligned
    assign in_window = (addr[31:4] == CLINT_BASE[31:4]);

    always_comb begin
        case (op_size)
            lsu_pkg::SIZE_B: op_axsize = axi_pkg::AXSIZE_B;
            lsu_pkg::SIZE_H: op_axsize = axi_pkg::AXSIZE_H;
            default:         op_axsize = axi_pkg::AXSIZE_W;
        endcase
    end

    // channel finished by the end of this cycle
    assign aw_done = !aw_pend || m_axi_awready;
    assign w_done  = !w_pend || m_axi_wready;

    assign m_axi_awvalid = aw_pend;
    assign m_axi_awaddr  = op_addr;
    assign m_axi_awsize  = op_axsize;
    assign m_axi_wvalid  = w_pend;
    assign m_axi_wdata   = op_wdata;
    assign m_axi_wstrb   = op_wstrb;
    assign m_axi_bready  = (state == AXI_WR_RESP);
    assign m_axi_arvalid = ar_pend;
    assign m_axi_araddr  = op_addr;
    assign m_axi_arsize  = op_axsize;
    assign m_axi_rready  = (state == AXI_RD_RESP);

    assign clint_sel   = (state == CLINT);
    assign clint_we    = op_we;
    assign clint_off   = op_addr[3:0];
    assign clint_wdata = op_wdata;
    assign clint_wstrb = op_wstrb;

    assign op_off = op_addr[1:0];

    // CLINT read word arrives registered in the done cycle
    assign raw_rdata = op_clint ? clint_rdata : axi_rdata;

    // request fields and read word
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            op_we     <= we;
            op_signed <= is_signed;
            op_size   <= size;
            op_addr   <= addr;
            op_wdata  <= wdata_aligned;
            op_wstrb  <= wstrb;
            op_clint  <= in_window;
        end
        if (state == AXI_RD_RESP && m_axi_rvalid) begin
            axi_rdata <= m_axi_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= IDLE;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            ar_pend <= 1'b0;
            done    <= 1'b0;
            err     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (req) begin
                        err <= 1'b0;
                        if (in_window) begin
                            state <= CLINT;
                        end else if (we) begin
                            state   <= AXI_WR;
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                        end else begin
                            state   <= AXI_RD;
                            ar_pend <= 1'b1;
                        end
                    end
                end
                CLINT: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                AXI_WR: begin
                    // aw and w drop on their own handshakes
                    if (m_axi_awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (m_axi_wready) begin
                        w_pend <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= AXI_WR_RESP;
                    end
                end
                AXI_WR_RESP: begin
                    if (m_axi_bvalid) begin
                        done  <= 1'b1;
                        err   <= resp_is_err(m_axi_bresp);
                        state <= IDLE;
                    end
                end
                AXI_RD: begin
                    if (m_axi_arready) begin
                        ar_pend <= 1'b0;
                        state   <= AXI_RD_RESP;
                    end
                end
                AXI_RD_RESP: begin
                    if (m_axi_rvalid) begin
                        done  <= 1'b1;
                        err   <= resp_is_err(m_axi_rresp);
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* src/lsu_load_extract.sv */
`timescale 1ns/1ps

module lsu_load_extract (
    input  lsu_pkg::mem_size_e size,
    input  logic [1:0]         off,
    input  logic               is_signed,
    input  logic [31:0]        raw_rdata,
    output logic [31:0]        rdata
);

    logic [31:0] shifted;
    logic        fill_b;
    logic        fill_h;

    // bring the addressed lane down to bit 0
    assign shifted = raw_rdata >> {off, 3'b000};

    // upper fill bit, zero for unsigned loads
    assign fill_b = shifted[7] & is_signed;
    assign fill_h = shifted[15] & is_signed;

    always_comb begin
        case (size)
            lsu_pkg::SIZE_B: begin
                rdata = {{24{fill_b}}, shifted[7:0]};
            end
            lsu_pkg::SIZE_H: begin
                rdata = {{16{fill_h}}, shifted[15:0]};
            end
            default: begin
                rdata = shifted;
            end
        endcase
    end

endmodule

/* src/lsu_pkg.sv */
package lsu_pkg;

    // access width, encoded to match the core's mask field
    typedef enum logic [1:0] {
        SIZE_B = 2'd1,
        SIZE_H = 2'd2,
        SIZE_W = 2'd3
    } mem_size_e;

    // register offsets inside the 16 byte CLINT window
    localparam logic [3:0] CLINT_MTIME_LO = 4'h0;
    localparam logic [3:0] CLINT_MTIME_HI = 4'h4;
    localparam logic [3:0] CLINT_CMP_LO   = 4'h8;
    localparam logic [3:0] CLINT_CMP_HI   = 4'hc;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } timer_halves_t;

    // 64-bit timer word, seen as one count or as two bus-sized halves
    typedef union packed {
        logic [63:0]   count;
        timer_halves_t half;
    } timer_word_u;

endpackage

/* src/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::mem_size_e size,
    input  logic [1:0]         off,
    input  logic [31:0]        wdata,
    output logic [31:0]        wdata_aligned,
    output logic [3:0]         wstrb
);

    // move the low bytes up to the addressed lane
    assign wdata_aligned = wdata << {off, 3'b000};

    always_comb begin
        case (size)
            lsu_pkg::SIZE_B: begin
                wstrb = 4'b0001 << off;
            end
            lsu_pkg::SIZE_H: begin
                // only off[1] matters for halves
                wstrb = off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wstrb = 4'b1111;
            end
        endcase
    end

endmodule

/* src/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter logic [31:0] CLINT_BASE  = 32'ha000_0040,
    parameter logic [63:0] MTIME_RESET = 64'h0
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic               we,
    input  logic               is_signed,
    input  lsu_pkg::mem_size_e size,
    input  logic [31:0]        addr,
    input  logic [31:0]        wdata,
    output logic [31:0]        rdata,
    output logic               done,
    output logic               err,
    output logic               timer_irq,
    output logic               m_axi_awvalid,
    input  logic               m_axi_awready,
    output logic [31:0]        m_axi_awaddr,
    output logic [2:0]         m_axi_awsize,
    output logic               m_axi_wvalid,
    input  logic               m_axi_wready,
    output logic [31:0]        m_axi_wdata,
    output logic [3:0]         m_axi_wstrb,
    input  logic               m_axi_bvalid,
    output logic               m_axi_bready,
    input  logic [1:0]         m_axi_bresp,
    output logic               m_axi_arvalid,
    input  logic               m_axi_arready,
    output logic [31:0]        m_axi_araddr,
    output logic [2:0]         m_axi_arsize,
    input  logic               m_axi_rvalid,
    output logic               m_axi_rready,
    input  logic [31:0]        m_axi_rdata,
    input  logic [1:0]         m_axi_rresp
);

    logic [31:0]        wdata_aligned;
    logic [3:0]         wstrb;
    lsu_pkg::mem_size_e op_size;
    logic [1:0]         op_off;
    logic               op_signed;
    logic [31:0]        raw_rdata;
    logic               clint_sel;
    logic               clint_we;
    logic [3:0]         clint_off;
    logic [31:0]        clint_wdata;
    logic [3:0]         clint_wstrb;
    logic [31:0]        clint_rdata;

    // aligned from the live request, latched by the controller at req
    lsu_store_align u_store_align (
        .size          (size),
        .off           (addr[1:0]),
        .wdata         (wdata),
        .wdata_aligned (wdata_aligned),
        .wstrb         (wstrb)
    );

    lsu_ctrl_fsm #(
        .CLINT_BASE (CLINT_BASE)
    ) u_ctrl_fsm (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .we            (we),
        .is_signed     (is_signed),
        .size          (size),
        .addr          (addr),
        .wdata_aligned (wdata_aligned),
        .wstrb         (wstrb),
        .op_size       (op_size),
        .op_off        (op_off),
        .op_signed     (op_signed),
        .raw_rdata     (raw_rdata),
        .done          (done),
        .err           (err),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awsize  (m_axi_awsize),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wstrb   (m_axi_wstrb),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready),
        .m_axi_bresp   (m_axi_bresp),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_araddr  (m_axi_araddr),
        .m_axi_arsize  (m_axi_arsize),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready),
        .m_axi_rdata   (m_axi_rdata),
        .m_axi_rresp   (m_axi_rresp),
        .clint_rdata   (clint_rdata),
        .clint_sel     (clint_sel),
        .clint_we      (clint_we),
        .clint_off     (clint_off),
        .clint_wdata   (clint_wdata),
        .clint_wstrb   (clint_wstrb)
    );

    lsu_load_extract u_load_extract (
        .size      (op_size),
        .off       (op_off),
        .is_signed (op_signed),
        .raw_rdata (raw_rdata),
        .rdata     (rdata)
    );

    clint_timer #(
        .MTIME_RESET (MTIME_RESET)
    ) u_clint_timer (
        .clk       (clk),
        .reset     (reset),
        .sel       (clint_sel),
        .we        (clint_we),
        .off       (clint_off),
        .wdata     (clint_wdata),
        .wstrb     (clint_wstrb),
        .rdata     (clint_rdata),
        .timer_irq (timer_irq)
    );

endmodule
